// ==== dv/llc_tag_golden.txt ====
// columns: address, write flag, scratchpad lock mask, expected hit (0 miss, 1 hit, 2 unknown)
// one lookup per line, all values in hex
000004c0 0 0 0
000004c4 0 0 1
000008c0 1 0 0
00000cc0 0 0 0
00000cc8 1 0 1
000010c0 0 0 0
000008c0 0 0 1
000014c0 0 0 0
000018c0 1 0 0
00001cc0 0 0 0
000020c0 0 0 0
000004c0 0 0 2
000020c0 0 1 2
000024c0 1 1 0
000024c0 0 1 1
00000040 0 1 0
00000044 1 1 1
00000048 0 3 2
000001c0 1 3 0
000005c0 1 3 0
000009c0 0 3 0
00000dc0 0 3 0
000001c0 0 0 2
000009c0 0 c 2

// ==== compile.f ====
verilog/llc_tag_pkg.sv
verilog/llc_evict_box.sv
verilog/llc_tag_store.sv
verilog/llc_lookup_ctrl.sv
verilog/llc_tag_top.sv
dv/llc_tag_sva.sv
dv/llc_tag_tb.sv

// ==== Bender.yml ====
# tag and replacement part of a set-associative last-level cache
package:
  name: llc_tag

dependencies: {}

sources:
  - verilog/llc_tag_pkg.sv
  - verilog/llc_evict_box.sv
  - verilog/llc_tag_store.sv
  - verilog/llc_lookup_ctrl.sv
  - verilog/llc_tag_top.sv
  - target: test
    files:
      - dv/llc_tag_sva.sv
      - dv/llc_tag_tb.sv

// ==== dv/llc_tag_tb.sv ====
// llc tag testbench
// Replays the golden lookup list against the tag part, keeps a reference model
// of tag, valid and dirty bits per set and checks every response against it.
`timescale 1ns/1ns
`default_nettype none

module llc_tag_tb;

  localparam int unsigned Ways          = 4;
  localparam int unsigned NumSets       = 2 ** llc_tag_pkg::IndexWidth;
  localparam int unsigned MaxLines      = 64;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned TimeoutMargin = 100;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   lookup_valid_i;
  llc_tag_pkg::llc_req_t  lookup_i;
  logic [Ways-1:0]        spm_lock_i;
  logic                   ready_o;
  logic                   resp_valid_o;
  llc_tag_pkg::llc_resp_t resp_o;
  logic [Ways-1:0]        resp_way_o;

  // four hex words per golden line, address then write then lock mask then hit
  logic [31:0] golden_mem [0:4*MaxLines-1];

  // reference copy of the tag array
  logic [llc_tag_pkg::TagWidth-1:0] model_tag   [NumSets][Ways];
  logic [Ways-1:0]                  model_valid [NumSets];
  logic [Ways-1:0]                  model_dirty [NumSets];

  int unsigned cycle_cnt     = 0;
  int unsigned timeout_limit = 32'hffff_ffff;

  llc_tag_top #(
    .Ways (Ways)
  ) llc_tag_top_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_i       (lookup_i),
    .spm_lock_i     (spm_lock_i),
    .ready_o        (ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_o         (resp_o),
    .resp_way_o     (resp_way_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic int unsigned count_assert_failures();
    return llc_tag_top_inst.llc_evict_box_inst.llc_tag_sva_inst.fail_cnt
         + llc_tag_top_inst.llc_lookup_ctrl_inst.llc_tag_sva_inst.fail_cnt;
  endfunction

  // whole run is bounded, and a failed assertion ends it on the next edge
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "run ended by the cycle limit");
    end else if (count_assert_failures() != 0) begin
      $display("an assertion on the eviction link or response strobe failed at %0t ns", $time);
      $display("TEST FAILED");
      $fatal(1, "run ended by a failed assertion");
    end
  end

  task automatic wait_ready();
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
  endtask

  // latency counts falling edges from the accepting edge up to the strobe
  task automatic wait_response(output int unsigned latency);
    latency = 0;
    do begin
      @(negedge clk_i);
      latency++;
    end while (!resp_valid_o);
  endtask

  task automatic run_lookup(input int unsigned line);
    llc_tag_pkg::llc_addr_u             addr;
    llc_tag_pkg::llc_req_t              req;
    logic [Ways-1:0]                    spm;
    logic [Ways-1:0]                    hit_vec;
    logic [Ways-1:0]                    free_vec;
    logic [31:0]                        exp_hit;
    logic [llc_tag_pkg::IndexWidth-1:0] idx;
    logic [llc_tag_pkg::TagWidth-1:0]   tag;
    logic [llc_tag_pkg::TagWidth-1:0]   prev_tag;
    logic                               prev_dirty;
    int unsigned                        latency;
    string                              where;
    addr.raw  = golden_mem[4*line];
    req.addr  = addr;
    req.write = golden_mem[4*line+1][0];
    spm       = golden_mem[4*line+2][Ways-1:0];
    exp_hit   = golden_mem[4*line+3];
    idx       = addr.fields.index;
    tag       = addr.fields.tag;
    where     = $sformatf("golden line %0d", line);
    // locked ways drop out of the compare, free ways are neither valid nor locked
    for (int w = 0; w < Ways; w++) begin
      hit_vec[w] = model_valid[idx][w] & ~spm[w] & (model_tag[idx][w] == tag);
    end
    free_vec = ~(model_valid[idx] | spm);

    // lock mask settles a cycle before the lookup is offered
    @(posedge clk_i);
    spm_lock_i <= spm;
    wait_ready();
    @(posedge clk_i);
    lookup_valid_i <= 1'b1;
    lookup_i       <= req;
    @(posedge clk_i);
    lookup_valid_i <= 1'b0;
    wait_response(latency);

    check_equal(ready_o, 1, {where, " ready in the response cycle"});
    check_equal(resp_o.hit, |hit_vec, {where, " hit against the model"});
    if (exp_hit != 2) begin
      check_equal(resp_o.hit, exp_hit, {where, " hit against the golden value"});
    end
    check_equal(resp_way_o & spm, 0, {where, " response names a locked way"});
    if (|hit_vec) begin
      check_equal(latency, 3, {where, " hit latency"});
      check_equal(resp_way_o, hit_vec, {where, " hit way"});
      check_equal(resp_o.evict, 0, {where, " evict on a hit"});
      check_equal(resp_o.old_tag, 0, {where, " old tag on a hit"});
      if (req.write) begin
        model_dirty[idx] = model_dirty[idx] | hit_vec;
      end
    end else begin
      check_equal(latency >= 4 && latency <= Ways + 4, 1, {where, " miss latency in range"});
      check_equal($countones(resp_way_o), 1, {where, " fill way is one-hot"});
      prev_dirty = |(model_dirty[idx] & resp_way_o);
      prev_tag   = '0;
      for (int w = 0; w < Ways; w++) begin
        if (resp_way_o[w]) begin
          prev_tag = model_tag[idx][w];
        end
      end
      if (free_vec != '0) begin
        check_equal(resp_way_o & ~free_vec, 0, {where, " fill skipped a free way"});
        check_equal(resp_o.evict, 0, {where, " evict on a free fill"});
        check_equal(resp_o.old_tag, 0, {where, " old tag on a free fill"});
      end else begin
        check_equal(resp_o.evict, prev_dirty, {where, " evict of the replaced line"});
        check_equal(resp_o.old_tag, prev_dirty ? prev_tag : '0, {where, " old tag"});
      end
      for (int w = 0; w < Ways; w++) begin
        if (resp_way_o[w]) begin
          model_tag[idx][w]   = tag;
          model_valid[idx][w] = 1'b1;
          model_dirty[idx][w] = req.write;
        end
      end
    end
  endtask

  initial begin
    int unsigned num_lines;
    arst_n_i       = 1'b0;
    lookup_valid_i = 1'b0;
    lookup_i       = '0;
    spm_lock_i     = '0;
    for (int s = 0; s < NumSets; s++) begin
      model_valid[s] = '0;
      model_dirty[s] = '0;
    end
    // words the file does not reach keep an expected hit value outside 0 to 2
    for (int i = 0; i < 4 * MaxLines; i++) begin
      golden_mem[i] = '1;
    end
    $readmemh("dv/llc_tag_golden.txt", golden_mem);
    num_lines = 0;
    while (num_lines < MaxLines && golden_mem[4*num_lines+3] <= 2) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("the golden file dv/llc_tag_golden.txt holds no lookups");
      $display("TEST FAILED");
      $fatal(1, "no stimulus");
    end
    // a miss takes at most Ways+3 edges, plus a few to offer the lookup
    timeout_limit = num_lines * (Ways + 4) + ResetCycles + TimeoutMargin;

    repeat (ResetCycles) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int unsigned line = 0; line < num_lines; line++) begin
      run_lookup(line);
    end
    // the strobe property of the last response settles one edge later
    repeat (3) @(posedge clk_i);
    if (count_assert_failures() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("an assertion on the eviction link or response strobe failed");
      $display("TEST FAILED");
      $fatal(1, "failed assertion at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== dv/llc_tag_sva.sv ====
// llc tag assertions
// Properties of the eviction link and of the response strobe, bound into
// the eviction unit and into the lookup controller.
`timescale 1ns/1ns
`default_nettype none

module llc_tag_sva #(
  parameter int unsigned Ways = 4
) (
  input wire logic            clk_i,
  input wire logic            arst_n_i,
  input wire logic            req_i,
  input wire logic [Ways-1:0] way_i,
  input wire logic            valid_i,
  input wire logic [Ways-1:0] spm_lock_i,
  input wire logic            resp_valid_i
);

  // running count of failed assertions in this instance
  int unsigned fail_cnt = 0;

  way_onehot_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(way_i))
    else begin
      $error("eviction way is neither one-hot nor zero");
      fail_cnt++;
    end

  // a valid choice always names a way
  valid_way_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> (way_i != '0))
    else begin
      $error("eviction valid without a selected way");
      fail_cnt++;
    end

  // with every way locked no fill could ever complete
  req_spm_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |-> (spm_lock_i != '1))
    else begin
      $error("eviction request while all ways are locked");
      fail_cnt++;
    end

  resp_single_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i |=> !resp_valid_i)
    else begin
      $error("response strobe high for two cycles");
      fail_cnt++;
    end

endmodule

// eviction unit side of the link, it has no response strobe
bind llc_evict_box llc_tag_sva #(.Ways(Ways)) llc_tag_sva_inst (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .req_i        (req_i),
  .way_i        (way_o),
  .valid_i      (valid_o),
  .spm_lock_i   (spm_lock_i),
  .resp_valid_i (1'b0)
);

// controller side of the link together with its response strobe
bind llc_lookup_ctrl llc_tag_sva #(.Ways(Ways)) llc_tag_sva_inst (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .req_i        (evict_req_o),
  .way_i        (evict_way_i),
  .valid_i      (evict_valid_i),
  .spm_lock_i   (spm_lock_i),
  .resp_valid_i (resp_valid_o)
);

`default_nettype wire

// ==== verilog/llc_tag_top.sv ====
// llc tag top
// Tag and replacement part of the last-level cache. Joins the lookup
// controller, the tag store and the eviction unit for a given associativity.
`timescale 1ns/1ns
`default_nettype none

module llc_tag_top #(
  parameter int unsigned Ways = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  lookup_valid_i,
  input  wire llc_tag_pkg::llc_req_t lookup_i,
  // scratchpad lock level, changed only between lookups
  input  wire logic [Ways-1:0]       spm_lock_i,
  output logic                       ready_o,
  output logic                       resp_valid_o,
  output llc_tag_pkg::llc_resp_t     resp_o,
  output logic      [Ways-1:0]       resp_way_o
);

  // controller to tag store
  logic [llc_tag_pkg::IndexWidth-1:0]         rd_index;
  logic                                       wr_en;
  logic [llc_tag_pkg::IndexWidth-1:0]         wr_index;
  logic [Ways-1:0]                            wr_way;
  logic [llc_tag_pkg::TagWidth-1:0]           wr_tag;
  logic                                       wr_valid;
  logic                                       wr_dirty;

  // addressed set, seen by the controller and the eviction unit alike
  logic [Ways-1:0]                            set_valid;
  logic [Ways-1:0]                            set_dirty;
  logic [Ways-1:0][llc_tag_pkg::TagWidth-1:0] set_tag;

  // eviction handshake
  logic                                       evict_req;
  logic [Ways-1:0]                            evict_way;
  logic                                       evict;
  logic                                       evict_valid;

  llc_lookup_ctrl #(
    .Ways (Ways)
  ) llc_lookup_ctrl_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_i       (lookup_i),
    .spm_lock_i     (spm_lock_i),
    .valid_i        (set_valid),
    .dirty_i        (set_dirty),
    .tag_i          (set_tag),
    .evict_way_i    (evict_way),
    .evict_i        (evict),
    .evict_valid_i  (evict_valid),
    .ready_o        (ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_o         (resp_o),
    .resp_way_o     (resp_way_o),
    .evict_req_o    (evict_req),
    .rd_index_o     (rd_index),
    .wr_en_o        (wr_en),
    .wr_index_o     (wr_index),
    .wr_way_o       (wr_way),
    .wr_tag_o       (wr_tag),
    .wr_valid_o     (wr_valid),
    .wr_dirty_o     (wr_dirty)
  );

  llc_tag_store #(
    .Ways (Ways)
  ) llc_tag_store_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rd_index_i (rd_index),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_way_i   (wr_way),
    .wr_tag_i   (wr_tag),
    .wr_valid_i (wr_valid),
    .wr_dirty_i (wr_dirty),
    .valid_o    (set_valid),
    .dirty_o    (set_dirty),
    .tag_o      (set_tag)
  );

  llc_evict_box #(
    .Ways (Ways)
  ) llc_evict_box_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (evict_req),
    .tag_valid_i (set_valid),
    .tag_dirty_i (set_dirty),
    .spm_lock_i  (spm_lock_i),
    .way_o       (evict_way),
    .evict_o     (evict),
    .valid_o     (evict_valid)
  );

endmodule

`default_nettype wire

// ==== verilog/llc_lookup_ctrl.sv ====
// llc lookup controller
// Accepts one lookup at a time, compares its tag against the addressed set and
// either answers a hit or installs the tag in the way named by the eviction unit.
`timescale 1ns/1ns
`default_nettype none

module llc_lookup_ctrl #(
  parameter int unsigned Ways = 4
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  wire logic                                       lookup_valid_i,
  input  wire llc_tag_pkg::llc_req_t                      lookup_i,
  // scratchpad ways never hit
  input  wire logic [Ways-1:0]                            spm_lock_i,
  // addressed set from the tag store
  input  wire logic [Ways-1:0]                            valid_i,
  input  wire logic [Ways-1:0]                            dirty_i,
  input  wire logic [Ways-1:0][llc_tag_pkg::TagWidth-1:0] tag_i,
  // choice of the eviction unit
  input  wire logic [Ways-1:0]                            evict_way_i,
  input  wire logic                                       evict_i,
  input  wire logic                                       evict_valid_i,
  output logic                                            ready_o,
  output logic                                            resp_valid_o,
  output llc_tag_pkg::llc_resp_t                          resp_o,
  output logic      [Ways-1:0]                            resp_way_o,
  output logic                                            evict_req_o,
  // tag store read and write port
  output logic      [llc_tag_pkg::IndexWidth-1:0]         rd_index_o,
  output logic                                            wr_en_o,
  output logic      [llc_tag_pkg::IndexWidth-1:0]         wr_index_o,
  output logic      [Ways-1:0]                            wr_way_o,
  output logic      [llc_tag_pkg::TagWidth-1:0]           wr_tag_o,
  output logic                                            wr_valid_o,
  output logic                                            wr_dirty_o
);

  // FSM encoding
  localparam logic [2:0] StIdle    = 3'd0;
  localparam logic [2:0] StCompare = 3'd1;
  localparam logic [2:0] StDecide  = 3'd2;
  localparam logic [2:0] StEvict   = 3'd3;
  localparam logic [2:0] StResp    = 3'd4;

  logic [2:0]                      state_q, state_d;
  logic                            accept;
  llc_tag_pkg::llc_req_t           req_q;
  logic [Ways-1:0]                 hit_vec;
  logic                            hit_q;
  logic [Ways-1:0]                 hit_way_q;
  logic                            hit_dirty;
  logic [llc_tag_pkg::TagWidth-1:0] victim_tag;
  llc_tag_pkg::llc_resp_t          resp_q;
  logic [Ways-1:0]                 resp_way_q;

  // a new lookup may enter while idle and also in the response cycle
  assign ready_o      = (state_q == StIdle) || (state_q == StResp);
  assign accept       = lookup_valid_i & ready_o;
  assign resp_valid_o = (state_q == StResp);
  assign resp_o       = resp_q;
  assign resp_way_o   = resp_way_q;

  // the eviction request stays up until the unit names a way
  assign evict_req_o  = (state_q == StEvict);

  // the store always shows the set of the lookup in flight
  assign rd_index_o   = req_q.addr.fields.index;

  // only valid ways outside the scratchpad take part in the compare
  always_comb begin
    for (int unsigned w = 0; w < Ways; w++) begin
      hit_vec[w] = valid_i[w] & ~spm_lock_i[w] & (tag_i[w] == req_q.addr.fields.tag);
    end
  end

  // a line that is already dirty needs no second write
  assign hit_dirty = |(dirty_i & hit_way_q);

  // tag of the way the eviction unit picked, built as an and-or mux
  always_comb begin
    victim_tag = '0;
    for (int unsigned w = 0; w < Ways; w++) begin
      victim_tag = victim_tag | (tag_i[w] & {llc_tag_pkg::TagWidth{evict_way_i[w]}});
    end
  end

  // tag store updates
  // a write hit sets dirty in the hitting way, a fill installs the new line
  always_comb begin
    wr_en_o    = 1'b0;
    wr_way_o   = '0;
    wr_valid_o = 1'b1;
    wr_dirty_o = 1'b1;
    if ((state_q == StDecide) && hit_q && req_q.write && !hit_dirty) begin
      wr_en_o  = 1'b1;
      wr_way_o = hit_way_q;
    end else if ((state_q == StEvict) && evict_valid_i) begin
      wr_en_o    = 1'b1;
      wr_way_o   = evict_way_i;
      wr_dirty_o = req_q.write;
    end
  end

  assign wr_index_o = req_q.addr.fields.index;
  assign wr_tag_o   = req_q.addr.fields.tag;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (accept) begin
          state_d = StCompare;
        end
      end
      StCompare: state_d = StDecide;
      StDecide: begin
        state_d = hit_q ? StResp : StEvict;
      end
      StEvict: begin
        if (evict_valid_i) begin
          state_d = StResp;
        end
      end
      StResp: begin
        state_d = accept ? StCompare : StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
      hit_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == StCompare) begin
        hit_q <= |hit_vec;
      end
    end
  end

  // request, hit way and response are payload and follow the FSM
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= lookup_i;
    end
    if (state_q == StCompare) begin
      hit_way_q <= hit_vec;
    end
    if ((state_q == StDecide) && hit_q) begin
      resp_q.hit     <= 1'b1;
      resp_q.evict   <= 1'b0;
      resp_q.old_tag <= '0;
      resp_way_q     <= hit_way_q;
    end else if ((state_q == StEvict) && evict_valid_i) begin
      resp_q.hit     <= 1'b0;
      resp_q.evict   <= evict_i;
      resp_q.old_tag <= evict_i ? victim_tag : '0;
      resp_way_q     <= evict_way_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/llc_tag_store.sv ====
// llc tag store
// Tag, valid and dirty bits for every set and way, kept in flip-flops. The
// whole addressed set is read combinationally and one way is written per edge.
`timescale 1ns/1ns
`default_nettype none

module llc_tag_store #(
  parameter int unsigned Ways = 4
) (
  input  wire logic                                               clk_i,
  input  wire logic                                               arst_n_i,
  // set that is presented on the read outputs
  input  wire logic [llc_tag_pkg::IndexWidth-1:0]                 rd_index_i,
  input  wire logic                                               wr_en_i,
  input  wire logic [llc_tag_pkg::IndexWidth-1:0]                 wr_index_i,
  // way to update, one-hot
  input  wire logic [Ways-1:0]                                    wr_way_i,
  input  wire logic [llc_tag_pkg::TagWidth-1:0]                   wr_tag_i,
  input  wire logic                                               wr_valid_i,
  input  wire logic                                               wr_dirty_i,
  output logic      [Ways-1:0]                                    valid_o,
  output logic      [Ways-1:0]                                    dirty_o,
  output logic      [Ways-1:0][llc_tag_pkg::TagWidth-1:0]         tag_o
);

  localparam int unsigned NumSets = 2 ** llc_tag_pkg::IndexWidth;

  logic [NumSets-1:0][Ways-1:0][llc_tag_pkg::TagWidth-1:0] tag_q;
  logic [NumSets-1:0][Ways-1:0]                            valid_q;
  logic [NumSets-1:0][Ways-1:0]                            dirty_q;

  // the read port hands out the full set so that all ways compare at once
  assign valid_o = valid_q[rd_index_i];
  assign dirty_o = dirty_q[rd_index_i];
  assign tag_o   = tag_q[rd_index_i];

  // status bits start cleared so that every set looks empty after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en_i) begin
      for (int unsigned w = 0; w < Ways; w++) begin
        if (wr_way_i[w]) begin
          valid_q[wr_index_i][w] <= wr_valid_i;
          dirty_q[wr_index_i][w] <= wr_dirty_i;
        end
      end
    end
  end

  // tags have no meaning while their valid bit is low
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int unsigned w = 0; w < Ways; w++) begin
        if (wr_way_i[w]) begin
          tag_q[wr_index_i][w] <= wr_tag_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/llc_evict_box.sv ====
// llc eviction unit
// Picks the way that a miss fills. A free way is taken when the set has one,
// otherwise a pseudo-random way that is not locked as scratchpad. The dirty bit
// of the chosen way tells the caller that the old line has to be written back.
`timescale 1ns/1ns
`default_nettype none

module llc_evict_box #(
  parameter int unsigned Ways = 4
) (
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  // held high by the lookup unit until valid_o has been seen
  input  wire logic            req_i,
  // valid bits of the addressed set
  input  wire logic [Ways-1:0] tag_valid_i,
  // dirty bits of the addressed set
  input  wire logic [Ways-1:0] tag_dirty_i,
  // ways locked as scratchpad, never all ones
  input  wire logic [Ways-1:0] spm_lock_i,
  // chosen way, one-hot, zero while nothing is chosen
  output logic      [Ways-1:0] way_o,
  // the chosen line is dirty and must be written back
  output logic                 evict_o,
  output logic                 valid_o
);

  // a way counts as occupied when it holds a line or belongs to the scratchpad
  logic [Ways-1:0] occupied;
  logic [Ways-1:0] ptr_q;
  logic            ptr_en;

  assign occupied = tag_valid_i | spm_lock_i;

  // the pointer stands still only while a pending request is being answered
  assign ptr_en = ~(req_i & valid_o);

  always_comb begin
    way_o   = '0;
    evict_o = 1'b0;
    valid_o = 1'b0;
    if (req_i) begin
      if (occupied == '1) begin
        // set is full, any way outside the scratchpad may be replaced
        if ((spm_lock_i & ptr_q) == '0) begin
          way_o   = ptr_q;
          valid_o = 1'b1;
          evict_o = |(tag_dirty_i & ptr_q);
        end
      end else if ((occupied & ptr_q) == '0) begin
        // a free way exists, so wait until the pointer lands on one
        way_o   = ptr_q;
        valid_o = 1'b1;
      end
    end
  end

  if (Ways > 1) begin : gen_rotate
    // a single one circulates through the ways and acts as the random source
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        ptr_q <= Ways'(1);
      end else if (ptr_en) begin
        ptr_q <= {ptr_q[Ways-2:0], ptr_q[Ways-1]};
      end
    end
  end else begin : gen_single
    // only one way exists and it is always the candidate
    assign ptr_q = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/llc_tag_pkg.sv ====
// llc tag package
// Address geometry of the last-level cache tag part and the types that carry
// lookups and their results between the caller and the lookup unit.
`default_nettype none

package llc_tag_pkg;

  // full byte address as seen by the caller
  localparam int unsigned AddrWidth   = 32;
  // byte offset inside one cache line, 64-byte lines
  localparam int unsigned OffsetWidth = 6;
  // set index, giving 16 sets
  localparam int unsigned IndexWidth  = 4;
  // whatever is left above index and offset is stored as the tag
  localparam int unsigned TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

  // the address split into the fields the tag lookup works on
  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] offset;
  } llc_addr_fields_t;

  // one address word, seen either as a plain word or as its cache fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    llc_addr_fields_t     fields;
  } llc_addr_u;

  // lookup request as handed in by the caller
  typedef struct packed {
    llc_addr_u addr;
    // a write marks the line dirty on a hit or on the fill
    logic      write;
  } llc_req_t;

  // lookup result, returned together with a one-hot way
  typedef struct packed {
    logic                hit;
    // set when a dirty line was pushed out by the fill
    logic                evict;
    // tag of the replaced dirty line, zero otherwise
    logic [TagWidth-1:0] old_tag;
  } llc_resp_t;

endpackage

`default_nettype wire
